/* src/mbox_bus_pkg.sv */
`default_nettype none

package mbox_bus_pkg;

   // bus geometry
   localparam int AXIL_AW = 4;    // byte address, four word registers
   localparam int AXIL_DW = 32;

   // response codes
   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   //##########################################################################
   // channel structs, ready runs the other way as a plain port
   //##########################################################################

   typedef struct packed {
      logic               valid;
      logic [AXIL_AW-1:0] addr;
   } axil_aw_t;                   // 5 bits

   typedef struct packed {
      logic                 valid;
      logic [AXIL_DW-1:0]   data;
      logic [AXIL_DW/8-1:0] strb; // carried but not acted on
   } axil_w_t;                    // 37 bits

   typedef struct packed {
      logic       valid;
      logic [1:0] resp;
   } axil_b_t;                    // 3 bits

   typedef struct packed {
      logic               valid;
      logic [AXIL_AW-1:0] addr;
   } axil_ar_t;                   // 5 bits

   typedef struct packed {
      logic               valid;
      logic [AXIL_DW-1:0] data;
      logic [1:0]         resp;
   } axil_r_t;                    // 35 bits

endpackage

`default_nettype wire

/* src/mbox_msg_pkg.sv */
`default_nettype none

package mbox_msg_pkg;

   // one mailbox entry
   typedef struct packed {
      logic [1:0]  tag;  // from write address bits 3..2
      logic [31:0] data;
   } mbox_msg_t;         // 34 bits

   //##########################################################################
   // read side register map
   //##########################################################################

   localparam logic [3:0] reg_pop    = 4'h0;  // pops head message
   localparam logic [3:0] reg_status = 4'h4;
   localparam logic [3:0] reg_tag    = 4'h8;  // tag of last pop

   // status word layout
   localparam int status_empty_bit = 0;
   localparam int status_count_lsb = 8;  // count field, AW+1 bits wide

endpackage

`default_nettype wire

/* src/mbox_ptr_sync.sv */
`default_nettype none

// carries one wrap-bit pointer across a clock boundary
module mbox_ptr_sync #(
   parameter int AW          = 3,
   parameter int SYNC_STAGES = 2
) (
   input  logic        src_clk,     // source domain
   input  logic        src_nreset,
   input  logic        clk,         // destination domain
   input  logic        nreset,
   input  logic [AW:0] bin_in,
   output logic [AW:0] bin_out
);

   logic [AW:0] gray_src;                // launch flop, source side
   logic [AW:0] sync_q [SYNC_STAGES];    // capture chain, destination side
   logic [AW:0] gray_dst;

   // binary to gray, registered so no combinational glitch crosses
   always_ff @(posedge src_clk or negedge src_nreset) begin
      if (!src_nreset)
         gray_src <= '0;
      else
         gray_src <= bin_in ^ (bin_in >> 1);
   end

   // only one bit moves per step, so per-bit sync is safe
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         for (int i = 0; i < SYNC_STAGES; i++)
            sync_q[i] <= '0;
      end else begin
         sync_q[0] <= gray_src;
         for (int i = 1; i < SYNC_STAGES; i++)
            sync_q[i] <= sync_q[i-1];
      end
   end

   assign gray_dst = sync_q[SYNC_STAGES-1];

   // gray back to binary, msb down
   always_comb begin
      bin_out[AW] = gray_dst[AW];
      for (int i = AW-1; i >= 0; i--)
         bin_out[i] = bin_out[i+1] ^ gray_dst[i];
   end

endmodule

`default_nettype wire

/* src/mbox_async_fifo.sv */
`default_nettype none

// dual clock fifo, first word fall through on the read side
module mbox_async_fifo #(
   parameter type payload_t   = logic [31:0],
   parameter int  DEPTH       = 8,   // power of two
   parameter int  SYNC_STAGES = 2
) (
   input  logic                   rd_nreset,  // raw async reset, both domains
   input  logic                   wr_clk,
   input  logic                   rd_clk,
   output logic                   wr_nreset,  // released in write domain
   // write side
   input  logic                   push,
   input  payload_t               push_msg,
   output logic                   full,
   // read side
   input  logic                   pop,
   output payload_t               pop_msg,
   output logic                   empty,
   output logic [$clog2(DEPTH):0] rd_count    // pessimistic fill level
);

   localparam int AW = $clog2(DEPTH);

   logic [SYNC_STAGES-1:0] wr_rst_q;
   logic [SYNC_STAGES-1:0] rd_rst_q;
   logic                   rd_nreset_sync;

   logic [AW:0] wr_ptr;     // extra msb is the wrap bit
   logic [AW:0] rd_ptr;
   logic [AW:0] wr_ptr_rd;  // write pointer seen on rd_clk
   logic [AW:0] rd_ptr_wr;  // read pointer seen on wr_clk
   logic        wr_en;
   logic        rd_en;

   payload_t mem [DEPTH];

   //##########################################################################
   // reset synchronizers, async assert and clocked release
   //##########################################################################

   always_ff @(posedge wr_clk or negedge rd_nreset) begin
      if (!rd_nreset)
         wr_rst_q <= '0;
      else
         wr_rst_q <= (wr_rst_q << 1) | 1'b1;  // shift ones in
   end

   always_ff @(posedge rd_clk or negedge rd_nreset) begin
      if (!rd_nreset)
         rd_rst_q <= '0;
      else
         rd_rst_q <= (rd_rst_q << 1) | 1'b1;
   end

   assign wr_nreset      = wr_rst_q[SYNC_STAGES-1];
   assign rd_nreset_sync = rd_rst_q[SYNC_STAGES-1];

   //##########################################################################
   // pointers and flags
   //##########################################################################

   assign wr_en = push & ~full;   // guard, writer already respects full
   assign rd_en = pop & ~empty;

   always_ff @(posedge wr_clk or negedge wr_nreset) begin
      if (!wr_nreset)
         wr_ptr <= '0;
      else if (wr_en)
         wr_ptr <= wr_ptr + 1'b1;
   end

   always_ff @(posedge rd_clk or negedge rd_nreset_sync) begin
      if (!rd_nreset_sync)
         rd_ptr <= '0;
      else if (rd_en)
         rd_ptr <= rd_ptr + 1'b1;
   end

   mbox_ptr_sync #(.AW(AW), .SYNC_STAGES(SYNC_STAGES)) wr2rd_sync_i (
      .src_clk    (wr_clk),
      .src_nreset (wr_nreset),
      .clk        (rd_clk),
      .nreset     (rd_nreset_sync),
      .bin_in     (wr_ptr),
      .bin_out    (wr_ptr_rd)
   );

   mbox_ptr_sync #(.AW(AW), .SYNC_STAGES(SYNC_STAGES)) rd2wr_sync_i (
      .src_clk    (rd_clk),
      .src_nreset (rd_nreset_sync),
      .clk        (wr_clk),
      .nreset     (wr_nreset),
      .bin_in     (rd_ptr),
      .bin_out    (rd_ptr_wr)
   );

   // same slot, other lap
   assign full = (wr_ptr[AW-1:0] == rd_ptr_wr[AW-1:0]) & (wr_ptr[AW] != rd_ptr_wr[AW]);
   assign empty    = (rd_ptr == wr_ptr_rd);
   assign rd_count = wr_ptr_rd - rd_ptr;   // lags real fill, never overstates

   // storage, written on wr_clk and read without a clock
   always_ff @(posedge wr_clk) begin
      if (wr_en)
         mem[wr_ptr[AW-1:0]] <= push_msg;
   end

   assign pop_msg = mem[rd_ptr[AW-1:0]];   // head entry

endmodule

`default_nettype wire

/* src/mbox_axil_writer.sv */
`default_nettype none

// axi4-lite write slave, one accepted write becomes one fifo push
module mbox_axil_writer
   import mbox_bus_pkg::*;
   import mbox_msg_pkg::*;
(
   input  logic      wr_clk,
   input  logic      wr_nreset,
   // axi4-lite write channels
   input  axil_aw_t  s_aw,
   output logic      s_awready,
   input  axil_w_t   s_w,
   output logic      s_wready,
   output axil_b_t   s_b,
   input  logic      s_bready,
   // fifo write side
   input  logic      full,
   output logic      push,
   output mbox_msg_t push_msg
);

   logic b_pending;   // response owed to the host
   logic accept;

   // address and data taken together, one write in flight
   assign accept = s_aw.valid & s_w.valid & ~b_pending & ~full;

   assign s_awready = accept;   // one cycle pulse
   assign s_wready  = accept;

   // push in the accept cycle itself
   assign push          = accept;
   assign push_msg.tag  = s_aw.addr[3:2];   // word offset becomes the tag
   assign push_msg.data = s_w.data;         // strobes not applied

   //##########################################################################
   // write response
   //##########################################################################

   always_ff @(posedge wr_clk or negedge wr_nreset) begin
      if (!wr_nreset)
         b_pending <= 1'b0;
      else if (accept)
         b_pending <= 1'b1;   // bvalid one cycle after accept
      else if (s_bready)
         b_pending <= 1'b0;   // held until the host takes it
   end

   assign s_b.valid = b_pending;
   assign s_b.resp  = resp_okay;   // every accepted write lands

endmodule

`default_nettype wire

/* src/mbox_axil_reader.sv */
`default_nettype none

// axi4-lite read slave, pops messages and serves tag and status
module mbox_axil_reader
   import mbox_bus_pkg::*;
   import mbox_msg_pkg::*;
#(
   parameter int DEPTH = 8
) (
   input  logic                   rd_clk,
   input  logic                   rd_nreset,
   // axi4-lite read channels
   input  axil_ar_t               s_ar,
   output logic                   s_arready,
   output axil_r_t                s_r,
   input  logic                   s_rready,
   // fifo read side
   output logic                   pop,
   input  mbox_msg_t              pop_msg,
   input  logic                   empty,
   input  logic [$clog2(DEPTH):0] rd_count
);

   localparam int AW = $clog2(DEPTH);

   logic               r_valid;
   logic [AXIL_DW-1:0] r_data;     // response payload
   logic [1:0]         r_resp;
   logic [1:0]         tag_q;      // tag of last popped message
   logic               ar_hs;
   logic [AXIL_DW-1:0] rd_data_next;
   logic [1:0]         rd_resp_next;
   logic [AXIL_DW-1:0] status_word;

   assign s_arready = ~r_valid;   // free whenever no response waits
   assign ar_hs     = s_ar.valid & s_arready;

   // pop only on a pop read with data present
   assign pop = ar_hs & (s_ar.addr == reg_pop) & ~empty;

   always_comb begin
      status_word                                 = '0;
      status_word[status_empty_bit]               = empty;
      status_word[status_count_lsb +: AW+1]       = rd_count;
   end

   //##########################################################################
   // register decode
   //##########################################################################

   always_comb begin
      rd_data_next = '0;
      rd_resp_next = resp_okay;
      case (s_ar.addr)
         reg_pop: begin
            if (empty)
               rd_resp_next = resp_slverr;   // nothing to pop
            else
               rd_data_next = pop_msg.data;
         end
         reg_status: rd_data_next = status_word;
         reg_tag:    rd_data_next[1:0] = tag_q;
         default:    rd_resp_next = resp_slverr;   // unmapped offset
      endcase
   end

   always_ff @(posedge rd_clk or negedge rd_nreset) begin
      if (!rd_nreset) begin
         r_valid <= 1'b0;
         tag_q   <= 2'b00;
      end else begin
         if (ar_hs)
            r_valid <= 1'b1;
         else if (s_rready)
            r_valid <= 1'b0;
         if (pop)
            tag_q <= pop_msg.tag;   // latched with the popped word
      end
   end

   // response payload, only looked at while r_valid
   always_ff @(posedge rd_clk) begin
      if (ar_hs) begin
         r_data <= rd_data_next;
         r_resp <= rd_resp_next;
      end
   end

   assign s_r.valid = r_valid;
   assign s_r.data  = r_data;
   assign s_r.resp  = r_resp;

endmodule

`default_nettype wire

/* src/cdc_mailbox.sv */
`default_nettype none

// mailbox top, host writes on wr_clk and reads back on rd_clk
module cdc_mailbox
   import mbox_bus_pkg::*;
   import mbox_msg_pkg::*;
#(
   parameter int DEPTH       = 8,
   parameter int SYNC_STAGES = 2
) (
   input  logic     rd_nreset,   // async, both domains
   // write domain
   input  logic     wr_clk,
   input  axil_aw_t s_aw,
   output logic     s_awready,
   input  axil_w_t  s_w,
   output logic     s_wready,
   output axil_b_t  s_b,
   input  logic     s_bready,
   // read domain
   input  logic     rd_clk,
   input  axil_ar_t s_ar,
   output logic     s_arready,
   output axil_r_t  s_r,
   input  logic     s_rready
);

   localparam int AW = $clog2(DEPTH);

   logic        wr_nreset;   // released by the fifo synchronizer
   logic        push;
   mbox_msg_t   push_msg;
   logic        full;
   logic        pop;
   mbox_msg_t   pop_msg;
   logic        empty;
   logic [AW:0] rd_count;

   mbox_axil_writer writer_i (
      .wr_clk    (wr_clk),
      .wr_nreset (wr_nreset),
      .s_aw      (s_aw),
      .s_awready (s_awready),
      .s_w       (s_w),
      .s_wready  (s_wready),
      .s_b       (s_b),
      .s_bready  (s_bready),
      .full      (full),
      .push      (push),
      .push_msg  (push_msg)
   );

   mbox_async_fifo #(
      .payload_t   (mbox_msg_t),
      .DEPTH       (DEPTH),
      .SYNC_STAGES (SYNC_STAGES)
   ) fifo_i (
      .rd_nreset (rd_nreset),
      .wr_clk    (wr_clk),
      .rd_clk    (rd_clk),
      .wr_nreset (wr_nreset),
      .push      (push),
      .push_msg  (push_msg),
      .full      (full),
      .pop       (pop),
      .pop_msg   (pop_msg),
      .empty     (empty),
      .rd_count  (rd_count)
   );

   mbox_axil_reader #(.DEPTH(DEPTH)) reader_i (
      .rd_clk    (rd_clk),
      .rd_nreset (rd_nreset),
      .s_ar      (s_ar),
      .s_arready (s_arready),
      .s_r       (s_r),
      .s_rready  (s_rready),
      .pop       (pop),
      .pop_msg   (pop_msg),
      .empty     (empty),
      .rd_count  (rd_count)
   );

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`default_nettype none

// free running clock for the testbench
module tb_clock #(
   parameter int PERIOD = 40   // ns
) (
   output logic clk
);

   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD / 2) clk = ~clk;   // even duty cycle
      end
   end

endmodule

`default_nettype wire

/* verification/cdc_mailbox_properties.sv */
`default_nettype none

// bus and fifo rules checked on the mailbox top
module cdc_mailbox_properties
   import mbox_bus_pkg::*;
(
   input logic    wr_clk,
   input logic    rd_clk,
   input logic    rd_nreset,
   input axil_b_t s_b,
   input logic    s_bready,
   input axil_r_t s_r,
   input logic    s_rready,
   input logic    push,
   input logic    full,
   input logic    pop,
   input logic    empty
);

   timeunit 1ns;
   timeprecision 1ps;

   // write response held until bready
   b_valid_held: assert property (@(posedge wr_clk) disable iff (!rd_nreset)
      s_b.valid && !s_bready |=> s_b.valid)
      else $error("write response dropped before bready");

   // read response held with its payload until rready
   r_valid_held: assert property (@(posedge rd_clk) disable iff (!rd_nreset)
      s_r.valid && !s_rready |=> s_r.valid && $stable(s_r.data) && $stable(s_r.resp))
      else $error("read response changed before rready");

   no_push_full: assert property (@(posedge wr_clk) disable iff (!rd_nreset)
      push |-> !full)
      else $error("push while fifo full");

   no_pop_empty: assert property (@(posedge rd_clk) disable iff (!rd_nreset)
      pop |-> !empty)
      else $error("pop while fifo empty");

endmodule

bind cdc_mailbox cdc_mailbox_properties props_i (
   .wr_clk    (wr_clk),
   .rd_clk    (rd_clk),
   .rd_nreset (rd_nreset),
   .s_b       (s_b),
   .s_bready  (s_bready),
   .s_r       (s_r),
   .s_rready  (s_rready),
   .push      (push),
   .full      (full),
   .pop       (pop),
   .empty     (empty)
);

`default_nettype wire

/* verification/cdc_mailbox_tb.sv */
`default_nettype none

// directed tests for the cdc mailbox
module cdc_mailbox_tb
   import mbox_bus_pkg::*;
   import mbox_msg_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int DEPTH       = 8;
   localparam int AW          = $clog2(DEPTH);
   localparam int RD_PERIOD   = 40;
   localparam int WR_PERIOD   = 28;    // no common multiple nearby with rd_clk
   localparam int BUS_LIMIT   = 200;   // cycles per handshake wait
   localparam int POLL_LIMIT  = 100;   // status reads per poll
   localparam int N_MSGS      = 3 + 4 + (DEPTH + 1) + 32;
   localparam int WATCHDOG_NS = (N_MSGS * 100 + 500) * RD_PERIOD;

   logic      rd_clk;
   logic      wr_clk;
   logic      rd_nreset;
   axil_aw_t  s_aw;
   logic      s_awready;
   axil_w_t   s_w;
   logic      s_wready;
   axil_b_t   s_b;
   logic      s_bready;
   axil_ar_t  s_ar;
   logic      s_arready;
   axil_r_t   s_r;
   logic      s_rready;

   mbox_msg_t model [$];          // messages posted and not yet popped
   integer    seed = 21136;
   string     test_name = "reset";

   tb_clock #(.PERIOD(RD_PERIOD)) rd_clock_i (.clk(rd_clk));
   tb_clock #(.PERIOD(WR_PERIOD)) wr_clock_i (.clk(wr_clk));

   cdc_mailbox #(.DEPTH(DEPTH), .SYNC_STAGES(2)) cdc_mailbox_i (
      .rd_nreset (rd_nreset),
      .wr_clk    (wr_clk),
      .s_aw      (s_aw),
      .s_awready (s_awready),
      .s_w       (s_w),
      .s_wready  (s_wready),
      .s_b       (s_b),
      .s_bready  (s_bready),
      .rd_clk    (rd_clk),
      .s_ar      (s_ar),
      .s_arready (s_arready),
      .s_r       (s_r),
      .s_rready  (s_rready)
   );

   //##########################################################################
   // failure reporting and the compare task
   //##########################################################################

   task automatic stop_with_failure();
      $display("STATUS: FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check(input string what, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected) begin
         $display("FAIL %s %s: expected %0h actual %0h", test_name, what, expected, actual);
         stop_with_failure();
      end
   endtask

   task automatic bus_timeout(input string what);
      $display("ERROR: %s in test %s got no answer within %0d cycles",
               what, test_name, BUS_LIMIT);
      stop_with_failure();
   endtask

   //##########################################################################
   // bus tasks driven and sampled on falling edges
   //##########################################################################

   task automatic write_start(input logic [3:0] addr, input logic [31:0] data);
      @(negedge wr_clk);
      s_aw.valid = 1'b1;
      s_aw.addr  = addr;
      s_w.valid  = 1'b1;
      s_w.data   = data;
      s_w.strb   = 4'hf;
   endtask

   // bvalid rising the cycle after the accept marks the handshake
   task automatic write_finish();
      int n;
      n = 0;
      do begin
         @(negedge wr_clk);
         n++;
         if (n > BUS_LIMIT)
            bus_timeout("write");
      end while (!s_b.valid);
      s_aw.valid = 1'b0;
      s_w.valid  = 1'b0;
      s_bready   = 1'b1;
      check("write resp", 32'(resp_okay), 32'(s_b.resp));
      @(negedge wr_clk);
      s_bready = 1'b0;
   endtask

   task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
      write_start(addr, data);
      write_finish();
   endtask

   task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
      int n;
      @(negedge rd_clk);
      s_ar.valid = 1'b1;
      s_ar.addr  = addr;
      n = 0;
      do begin
         @(negedge rd_clk);
         n++;
         if (n > BUS_LIMIT)
            bus_timeout("read");
      end while (!s_r.valid);
      data       = s_r.data;   // held until rready
      resp       = s_r.resp;
      s_ar.valid = 1'b0;
      s_rready   = 1'b1;
      @(negedge rd_clk);
      s_rready = 1'b0;
   endtask

   //##########################################################################
   // mailbox level helpers
   //##########################################################################

   // tag rides in address bits 3..2
   task automatic post(input logic [1:0] tag, input logic [31:0] data);
      mbox_msg_t msg;
      msg.tag  = tag;
      msg.data = data;
      axil_write({tag, 2'b00}, data);
      model.push_back(msg);
   endtask

   task automatic read_status(output logic empty_bit, output logic [AW:0] count);
      logic [31:0] data;
      logic [1:0]  resp;
      axil_read(reg_status, data, resp);
      check("status resp", 32'(resp_okay), 32'(resp));
      empty_bit = data[status_empty_bit];
      count     = data[status_count_lsb +: AW+1];
   endtask

   task automatic wait_count(input int want);
      logic        empty_bit;
      logic [AW:0] count;
      int          n;
      n = 0;
      do begin
         read_status(empty_bit, count);
         n++;
         if (n > POLL_LIMIT) begin
            $display("ERROR: status count in test %s never reached %0d", test_name, want);
            stop_with_failure();
         end
      end while (count != want);
      check("empty bit", 32'(want == 0), 32'(empty_bit));
   endtask

   // poll until the head shows up since crossing latency varies
   task automatic wait_filled();
      logic        empty_bit;
      logic [AW:0] count;
      int          n;
      n = 0;
      do begin
         read_status(empty_bit, count);
         n++;
         if (n > POLL_LIMIT) begin
            $display("ERROR: mailbox in test %s stayed empty", test_name);
            stop_with_failure();
         end
      end while (empty_bit);
   endtask

   task automatic pop_check();
      mbox_msg_t   exp;
      logic [31:0] data;
      logic [1:0]  resp;
      wait_filled();
      exp = model.pop_front();
      axil_read(reg_pop, data, resp);
      check("pop resp", 32'(resp_okay), 32'(resp));
      check("pop data", exp.data, data);
      axil_read(reg_tag, data, resp);
      check("tag resp", 32'(resp_okay), 32'(resp));
      check("tag", 32'(exp.tag), data);
   endtask

   //##########################################################################
   // directed tests
   //##########################################################################

   task automatic reset_state();
      logic [31:0] data;
      logic [1:0]  resp;
      test_name = "reset";
      @(negedge rd_clk);
      check("arready", 32'd1, 32'(s_arready));
      check("awready", 32'd0, 32'(s_awready));
      check("wready", 32'd0, 32'(s_wready));
      check("bvalid", 32'd0, 32'(s_b.valid));
      check("rvalid", 32'd0, 32'(s_r.valid));
      axil_read(reg_tag, data, resp);   // latched tag starts at zero
      check("tag", 32'd0, data);
      wait_count(0);
   endtask

   task automatic order_and_tags();
      test_name = "order_tags";
      post(2'd0, 32'($random(seed)));   // offset 0x0
      post(2'd1, 32'($random(seed)));   // offset 0x4
      post(2'd3, 32'($random(seed)));   // offset 0xc
      repeat (3) pop_check();
   endtask

   task automatic empty_pop_error();
      logic [31:0] data;
      logic [1:0]  resp;
      test_name = "empty_pop";
      axil_read(reg_pop, data, resp);
      check("pop resp", 32'(resp_slverr), 32'(resp));
      check("pop data", 32'd0, data);
      axil_read(4'hc, data, resp);       // unmapped
      check("unmapped resp", 32'(resp_slverr), 32'(resp));
      check("unmapped data", 32'd0, data);
   endtask

   task automatic status_count();
      test_name = "status";
      repeat (4) post(2'd0, 32'($random(seed)));
      wait_count(4);
      repeat (4) pop_check();
      wait_count(0);
   endtask

   task automatic full_backpressure();
      mbox_msg_t extra;
      test_name = "full_backpressure";
      repeat (DEPTH) post(2'd2, 32'($random(seed)));
      extra.tag  = 2'd1;
      extra.data = 32'($random(seed));
      write_start({extra.tag, 2'b00}, extra.data);
      model.push_back(extra);
      repeat (20) begin
         @(negedge wr_clk);
         check("awready while full", 32'd0, 32'(s_awready));
         check("wready while full", 32'd0, 32'(s_wready));
      end
      pop_check();      // frees one slot
      write_finish();   // stalled write now lands
      while (model.size() > 0)
         pop_check();
   endtask

   task automatic random_traffic();
      int sent;
      int burst;
      test_name = "random_traffic";
      sent = 0;
      while (sent < 32) begin
         burst = 1 + ($random(seed) & 3);
         // stay below depth as nothing drains while writing
         for (int i = 0; i < burst && sent < 32 && model.size() < DEPTH; i++) begin
            post(2'($random(seed)), 32'($random(seed)));
            sent++;
         end
         burst = 1 + ($random(seed) & 3);
         for (int i = 0; i < burst && model.size() > 0; i++)
            pop_check();
      end
      while (model.size() > 0)
         pop_check();
   endtask

   //##########################################################################
   // sequence and watchdog
   //##########################################################################

   initial begin
      rd_nreset = 1'b0;
      s_aw      = '0;
      s_w       = '0;
      s_bready  = 1'b0;
      s_ar      = '0;
      s_rready  = 1'b0;
      repeat (4) @(negedge rd_clk);
      rd_nreset = 1'b1;
      repeat (4) @(negedge wr_clk);   // let both reset synchronizers release
      reset_state();
      order_and_tags();
      empty_pop_error();
      status_count();
      full_backpressure();
      random_traffic();
      $display("STATUS: PASS");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("ERROR: watchdog expired after %0d ns in test %s", WATCHDOG_NS, test_name);
      stop_with_failure();
   end

endmodule

`default_nettype wire

/* list.f */
src/mbox_bus_pkg.sv
src/mbox_msg_pkg.sv
src/mbox_ptr_sync.sv
src/mbox_async_fifo.sv
src/mbox_axil_writer.sv
src/mbox_axil_reader.sv
src/cdc_mailbox.sv
verification/tb_clock.sv
verification/cdc_mailbox_properties.sv
verification/cdc_mailbox_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module cdc_mailbox_tb \
   -o cdc_mailbox_sim > build.log 2>&1 \
   && ./obj_dir/cdc_mailbox_sim > sim.log 2>&1
grep -q "^STATUS: PASS$" sim.log && echo "simulation passed" \
   || { echo "simulation failed, see build.log and sim.log"; exit 1; }
